// File: design/circular_queue.sv
module circular_queue #(
    type QUEUE_TYPE = ooo_types::phys_reg_t,
    parameter ooo_types::initialization_t INIT_TYPE = ooo_types::ZERO,
    parameter int SS      = 2,
    parameter int SEL_IN  = 2,
    parameter int SEL_OUT = 2,
    parameter int DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  logic                     pop,
    input  QUEUE_TYPE                in [SS],
    input  QUEUE_TYPE                reg_in [SEL_IN],
    input  logic [$clog2(DEPTH)-1:0] reg_select_in [SEL_IN],
    input  logic [SEL_IN-1:0]        in_bitmask,
    input  logic [$clog2(DEPTH)-1:0] reg_select_out [SEL_OUT],
    output logic                     empty,
    output logic                     full,
    output logic [$clog2(DEPTH)-1:0] head_out,
    output logic [$clog2(DEPTH)-1:0] tail_out,
    output QUEUE_TYPE                out [SS],
    output QUEUE_TYPE                reg_out [SEL_OUT]
);
    import ooo_types::*;

    localparam int IDX_W = $clog2(DEPTH);
    localparam int PTR_W = IDX_W + 1;

    QUEUE_TYPE        entries [DEPTH];
    logic [PTR_W-1:0] head;   // Top bit is the wrap bit
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] count;  // Occupied entries

    assign head_out = head[IDX_W-1:0];
    assign tail_out = tail[IDX_W-1:0];
    assign count    = head - tail;

    // Pushes and pops always move SS entries at once
    assign empty = (count < PTR_W'(SS));
    assign full  = (count > PTR_W'(DEPTH - SS));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail <= '0;
            if (INIT_TYPE == FREE_LIST) begin
                head <= PTR_W'(DEPTH);  // Starts out full
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= ($bits(QUEUE_TYPE))'(32 + i);
                end
            end else begin
                head <= '0;
                for (int i = 0; i < DEPTH; i++) begin
                    entries[i] <= '0;
                end
            end
        end else begin
            if (push) begin
                head <= head + PTR_W'(SS);
                for (int i = 0; i < SS; i++) begin
                    entries[IDX_W'(head_out + i)] <= in[i];
                end
            end
            if (pop) begin
                tail <= tail + PTR_W'(SS);
            end
            // Indexed writes land after the push so they win on a clash
            for (int i = 0; i < SEL_IN; i++) begin
                if (in_bitmask[i]) begin
                    entries[reg_select_in[i]] <= reg_in[i];
                end
            end
        end
    end

    // Oldest SS entries show up on out the cycle after a pop
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < SS; i++) begin
                out[i] <= entries[IDX_W'(tail_out + i)];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SEL_OUT; i++) begin
            reg_out[i] = entries[reg_select_out[i]];  // Peek without popping
        end
    end

endmodule : circular_queue

// File: design/ooo_types.sv
package ooo_types;

    // 64 physical registers, 0 to 31 start out mapped by the alias table
    typedef logic [5:0] phys_reg_t;

    // One ROB slot
    typedef struct packed {
        rv32i_types::arch_reg_t arch_rd;
        logic                   has_rd;
        phys_reg_t              new_preg;
        phys_reg_t              old_preg;  // Freed when this instruction retires
        logic                   done;
    } rob_entry_t;

    // Contents loaded into a queue by reset
    typedef enum logic {
        ZERO,       // Cleared and empty
        FREE_LIST   // Entry i holds 32+i, queue full
    } initialization_t;

endpackage : ooo_types

// File: design/rename_dispatch_top.sv
module rename_dispatch_top #(
    parameter int FREE_DEPTH = 32,
    parameter int ROB_DEPTH  = 16,
    parameter int SS         = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         dispatch_valid,
    input  rv32i_types::arch_reg_t       dispatch_rd [SS],
    input  rv32i_types::arch_reg_t       dispatch_rs1 [SS],
    input  rv32i_types::arch_reg_t       dispatch_rs2 [SS],
    input  logic                         dispatch_has_rd [SS],
    output logic                         dispatch_ready,
    output logic                         rename_valid,
    output ooo_types::phys_reg_t         rename_prd [SS],
    output ooo_types::phys_reg_t         rename_prs1 [SS],
    output ooo_types::phys_reg_t         rename_prs2 [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] rename_rob_idx [SS],
    input  logic                         done_valid [SS],
    input  logic [$clog2(ROB_DEPTH)-1:0] done_rob_idx [SS],
    output logic                         commit_valid,
    output rv32i_types::arch_reg_t       commit_rd [SS],
    output logic                         commit_has_rd [SS],
    output ooo_types::phys_reg_t         commit_preg [SS]
);
    import rv32i_types::*;
    import ooo_types::*;

    localparam int FREE_IDX_W = $clog2(FREE_DEPTH);
    localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);

    decoded_instr_t        dispatch_instr [SS];
    logic                  ready_en;  // Holds dispatch off until reset is over

    logic                  free_pop;
    logic                  free_push;
    logic                  free_empty;
    logic                  free_full;
    logic [FREE_IDX_W-1:0] free_tail;
    logic [FREE_IDX_W-1:0] free_sel_out [SS];
    phys_reg_t             free_preg [SS];
    phys_reg_t             free_return [SS];
    phys_reg_t             free_upd_val [1];
    logic [FREE_IDX_W-1:0] free_upd_sel [1];

    logic                  rob_push;
    logic                  rob_pop;
    logic                  rob_empty;
    logic                  rob_full;
    logic [ROB_IDX_W-1:0]  rob_head;
    logic [ROB_IDX_W-1:0]  rob_tail;
    rob_entry_t            rob_write [SS];
    logic [ROB_IDX_W-1:0]  rob_sel_in [SS];
    logic [ROB_IDX_W-1:0]  rob_sel_out [2*SS];
    logic [SS-1:0]         rob_write_mask;
    rob_entry_t            rob_peek [2*SS];
    rob_entry_t            rob_out [SS];

    rob_alloc_if #(.SS(SS), .ROB_DEPTH(ROB_DEPTH)) alloc_if ();

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            dispatch_instr[i] = '{
                rd:     dispatch_rd[i],
                rs1:    dispatch_rs1[i],
                rs2:    dispatch_rs2[i],
                has_rd: dispatch_has_rd[i]
            };
            free_sel_out[i] = FREE_IDX_W'(free_tail + i);  // Next two free registers
        end
    end

    assign free_upd_val[0] = '0;  // Free list never edits in place
    assign free_upd_sel[0] = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    assign dispatch_ready = ready_en && !free_empty && !rob_full;

    circular_queue #(
        .QUEUE_TYPE (phys_reg_t),
        .INIT_TYPE  (FREE_LIST),
        .SS         (SS),
        .SEL_IN     (1),
        .SEL_OUT    (SS),
        .DEPTH      (FREE_DEPTH)
    ) free_list (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (free_push),
        .pop            (free_pop),
        .in             (free_return),
        .reg_in         (free_upd_val),
        .reg_select_in  (free_upd_sel),
        .in_bitmask     (1'b0),
        .reg_select_out (free_sel_out),
        .empty          (free_empty),
        .full           (free_full),
        .head_out       (),
        .tail_out       (free_tail),
        .out            (),
        .reg_out        (free_preg)
    );

    circular_queue #(
        .QUEUE_TYPE (rob_entry_t),
        .INIT_TYPE  (ZERO),
        .SS         (SS),
        .SEL_IN     (SS),
        .SEL_OUT    (2*SS),
        .DEPTH      (ROB_DEPTH)
    ) rob (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (rob_push),
        .pop            (rob_pop),
        .in             (alloc_if.entry),
        .reg_in         (rob_write),
        .reg_select_in  (rob_sel_in),
        .in_bitmask     (rob_write_mask),
        .reg_select_out (rob_sel_out),
        .empty          (rob_empty),
        .full           (rob_full),
        .head_out       (rob_head),
        .tail_out       (rob_tail),
        .out            (rob_out),
        .reg_out        (rob_peek)
    );

    rename_map #(.SS(SS), .ROB_DEPTH(ROB_DEPTH)) rat (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_instr (dispatch_instr),
        .dispatch_ready (dispatch_ready),
        .free_preg      (free_preg),
        .free_pop       (free_pop),
        .rob            (alloc_if.rename),
        .rename_valid   (rename_valid),
        .rename_prd     (rename_prd),
        .rename_prs1    (rename_prs1),
        .rename_prs2    (rename_prs2),
        .rename_rob_idx (rename_rob_idx)
    );

    rob_commit_ctrl #(.SS(SS), .ROB_DEPTH(ROB_DEPTH)) commit_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .rob            (alloc_if.rob),
        .done_valid     (done_valid),
        .done_rob_idx   (done_rob_idx),
        .rob_empty      (rob_empty),
        .rob_full       (rob_full),
        .rob_head       (rob_head),
        .rob_tail       (rob_tail),
        .rob_peek       (rob_peek),
        .rob_out        (rob_out),
        .rob_push       (rob_push),
        .rob_pop        (rob_pop),
        .rob_write      (rob_write),
        .rob_sel_in     (rob_sel_in),
        .rob_sel_out    (rob_sel_out),
        .rob_write_mask (rob_write_mask),
        .free_push      (free_push),
        .free_return    (free_return),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_has_rd  (commit_has_rd),
        .commit_preg    (commit_preg)
    );

endmodule : rename_dispatch_top

// File: design/rename_map.sv
module rename_map #(
    parameter int SS        = 2,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         dispatch_valid,
    input  rv32i_types::decoded_instr_t  dispatch_instr [SS],
    input  logic                         dispatch_ready,
    input  ooo_types::phys_reg_t         free_preg [SS],
    output logic                         free_pop,
    rob_alloc_if.rename                  rob,
    output logic                         rename_valid,
    output ooo_types::phys_reg_t         rename_prd [SS],
    output ooo_types::phys_reg_t         rename_prs1 [SS],
    output ooo_types::phys_reg_t         rename_prs2 [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] rename_rob_idx [SS]
);
    import rv32i_types::*;
    import ooo_types::*;

    localparam int NUM_ARCH = 2 ** $bits(arch_reg_t);

    phys_reg_t rat [NUM_ARCH];  // Alias table
    logic      accept;
    logic      wr [SS];         // Instruction really remaps its rd
    phys_reg_t prs1 [SS];
    phys_reg_t prs2 [SS];
    phys_reg_t old_preg [SS];

    assign accept          = dispatch_valid && dispatch_ready;
    assign free_pop        = accept;
    assign rob.alloc_valid = accept;

    // Translate sources; later instructions of the pair see earlier destinations
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            wr[i]       = dispatch_instr[i].has_rd && (dispatch_instr[i].rd != '0);
            prs1[i]     = rat[dispatch_instr[i].rs1];
            prs2[i]     = rat[dispatch_instr[i].rs2];
            old_preg[i] = rat[dispatch_instr[i].rd];
            for (int j = 0; j < i; j++) begin
                if (wr[j] && (dispatch_instr[j].rd == dispatch_instr[i].rs1)) begin
                    prs1[i] = free_preg[j];
                end
                if (wr[j] && (dispatch_instr[j].rd == dispatch_instr[i].rs2)) begin
                    prs2[i] = free_preg[j];
                end
                if (wr[j] && (dispatch_instr[j].rd == dispatch_instr[i].rd)) begin
                    old_preg[i] = free_preg[j];
                end
            end
            // No real destination, so the new register itself is freed at commit
            if (!wr[i]) begin
                old_preg[i] = free_preg[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SS; i++) begin
            rob.entry[i] = '{
                arch_rd:  dispatch_instr[i].rd,
                has_rd:   dispatch_instr[i].has_rd,
                new_preg: free_preg[i],
                old_preg: old_preg[i],
                done:     1'b0
            };
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_ARCH; i++) begin
                rat[i] <= phys_reg_t'(i);  // Identity map, x0 stays on 0
            end
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= accept;
            if (accept) begin
                for (int i = 0; i < SS; i++) begin
                    if (wr[i]) begin
                        rat[dispatch_instr[i].rd] <= free_preg[i];  // Last writer wins
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < SS; i++) begin
                rename_prd[i]     <= free_preg[i];
                rename_prs1[i]    <= prs1[i];
                rename_prs2[i]    <= prs2[i];
                rename_rob_idx[i] <= rob.rob_idx[i];
            end
        end
    end

endmodule : rename_map

// File: design/rob_alloc_if.sv
interface rob_alloc_if #(
    parameter int SS        = 2,
    parameter int ROB_DEPTH = 16
);
    import ooo_types::*;

    logic                         alloc_valid;
    rob_entry_t                   entry [SS];    // New entries in program order
    logic [$clog2(ROB_DEPTH)-1:0] rob_idx [SS];  // Slots these entries land in

    modport rename (
        output alloc_valid,
        output entry,
        input  rob_idx
    );

    modport rob (
        input  alloc_valid,
        input  entry,
        output rob_idx
    );

endinterface : rob_alloc_if

// File: design/rob_commit_ctrl.sv
module rob_commit_ctrl #(
    parameter int SS        = 2,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    rob_alloc_if.rob                     rob,
    input  logic                         done_valid [SS],
    input  logic [$clog2(ROB_DEPTH)-1:0] done_rob_idx [SS],
    input  logic                         rob_empty,
    input  logic                         rob_full,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_head,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_tail,
    input  ooo_types::rob_entry_t        rob_peek [2*SS],
    input  ooo_types::rob_entry_t        rob_out [SS],
    output logic                         rob_push,
    output logic                         rob_pop,
    output ooo_types::rob_entry_t        rob_write [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] rob_sel_in [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] rob_sel_out [2*SS],
    output logic [SS-1:0]                rob_write_mask,
    output logic                         free_push,
    output ooo_types::phys_reg_t         free_return [SS],
    output logic                         commit_valid,
    output rv32i_types::arch_reg_t       commit_rd [SS],
    output logic                         commit_has_rd [SS],
    output ooo_types::phys_reg_t         commit_preg [SS]
);
    import ooo_types::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic retire;

    assign rob_push = rob.alloc_valid && !rob_full;

    // Peeks 0..SS-1 watch the oldest pair, the rest read back completing entries
    always_comb begin
        for (int k = 0; k < SS; k++) begin
            rob.rob_idx[k]      = IDX_W'(rob_head + k);
            rob_sel_out[k]      = IDX_W'(rob_tail + k);
            rob_sel_out[SS + k] = done_rob_idx[k];
            rob_sel_in[k]       = done_rob_idx[k];
            rob_write_mask[k]   = done_valid[k];
        end
    end

    always_comb begin
        rob_entry_t marked;
        for (int k = 0; k < SS; k++) begin
            marked       = rob_peek[SS + k];
            marked.done  = 1'b1;
            rob_write[k] = marked;
        end
    end

    // Retire only when the whole oldest pair is done
    always_comb begin
        retire = !rob_empty;
        for (int k = 0; k < SS; k++) begin
            if (!rob_peek[k].done) begin
                retire = 1'b0;
            end
        end
    end

    assign rob_pop   = retire;
    assign free_push = retire;

    always_comb begin
        for (int k = 0; k < SS; k++) begin
            free_return[k]   = rob_peek[k].old_preg;
            commit_rd[k]     = rob_out[k].arch_rd;   // Popped pair, registered by the ROB
            commit_has_rd[k] = rob_out[k].has_rd;
            commit_preg[k]   = rob_out[k].new_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;  // Lines up with rob_out
        end
    end

endmodule : rob_commit_ctrl

// File: design/rv32i_types.sv
package rv32i_types;

    // Architectural register number, x0 to x31
    typedef logic [4:0] arch_reg_t;

    // Fields of one decoded instruction that rename needs
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        logic      has_rd;  // Instruction writes rd
    } decoded_instr_t;

endpackage : rv32i_types

// File: flist.f
design/rv32i_types.sv
design/ooo_types.sv
design/rob_alloc_if.sv
design/circular_queue.sv
design/rename_map.sv
design/rob_commit_ctrl.sv
design/rename_dispatch_top.sv
tb/tb_clk_gen.sv
tb/rename_dispatch_assert.sv
tb/rename_dispatch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rename/dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_dispatch_tb -f flist.f -o rename_dispatch_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/rename_dispatch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/rename_dispatch_assert.sv
module rename_dispatch_assert (
    input logic clk,
    input logic rst_n,
    input logic dispatch_valid,
    input logic dispatch_ready,
    input logic rename_valid,
    input logic commit_valid,
    input logic free_push,
    input logic free_full
);
    // Renamed pair follows acceptance by exactly one cycle
    a_rename_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (dispatch_valid && dispatch_ready) |=> rename_valid)
        else $error("rename_valid missing one cycle after acceptance");

    a_no_rename_without_accept: assert property (@(posedge clk) disable iff (!rst_n)
        !(dispatch_valid && dispatch_ready) |=> !rename_valid)
        else $error("rename_valid without an accepted pair");

    // Reaches into the first cycle after release, where the ROB must come up empty
    a_no_commit_near_reset: assert property (@(posedge clk)
        $past(!rst_n) |=> !commit_valid)
        else $error("commit_valid within one cycle of reset");

    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(free_push && free_full))
        else $error("free list pushed while full");

endmodule : rename_dispatch_assert

bind rename_dispatch_top rename_dispatch_assert chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .rename_valid   (rename_valid),
    .commit_valid   (commit_valid),
    .free_push      (free_push),
    .free_full      (free_full)
);

// File: tb/rename_dispatch_tb.sv
module rename_dispatch_tb;
    localparam int PERIOD   = 40;
    localparam int NUM_ROWS = 20;

    typedef struct packed {
        logic [4:0]  rd0, rs1_0, rs2_0;
        logic        h0;
        logic [4:0]  rd1, rs1_1, rs2_1;
        logic        h1;
        logic        full_chk;   // Expect ROB full after this pair
        logic [15:0] done_mask;  // ROB indices completed after this pair
    } row_t;

    typedef struct {
        logic [4:0] rd;
        logic       has_rd;
        logic [5:0] new_p;
        logic [5:0] old_p;
        int         idx;
        bit         done;
    } mentry_t;

    logic       clk, rst_n;
    logic       dispatch_valid, dispatch_ready, rename_valid, commit_valid;
    logic [4:0] dispatch_rd [2], dispatch_rs1 [2], dispatch_rs2 [2];
    logic       dispatch_has_rd [2];
    logic [5:0] rename_prd [2], rename_prs1 [2], rename_prs2 [2];
    logic [3:0] rename_rob_idx [2];
    logic       done_valid [2];
    logic [3:0] done_rob_idx [2];
    logic [4:0] commit_rd [2];
    logic       commit_has_rd [2];
    logic [5:0] commit_preg [2];

    row_t       rows [NUM_ROWS];
    logic [5:0] rat_m [32];      // Model alias table
    logic [5:0] free_fifo [$];   // Model free list with the oldest first
    mentry_t    mrob [$];        // Model ROB in program order
    int         alloc_cnt;
    int         errors;
    int         checks;
    logic [5:0] exp_prd [2], exp_prs1 [2], exp_prs2 [2];
    int         exp_idx [2];

    tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(3)) clk_gen (.clk(clk), .rst_n(rst_n));

    rename_dispatch_top #(.FREE_DEPTH(32), .ROB_DEPTH(16), .SS(2)) uut (.*);

    task automatic check_hex(input string name, input int exp, input int got);
        checks++;
        if (exp != got) begin
            $display("error: %s expected 0x%0h got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic drive_pair(input row_t r);
        dispatch_rd[0]     <= r.rd0;
        dispatch_rs1[0]    <= r.rs1_0;
        dispatch_rs2[0]    <= r.rs2_0;
        dispatch_has_rd[0] <= r.h0;
        dispatch_rd[1]     <= r.rd1;
        dispatch_rs1[1]    <= r.rs1_1;
        dispatch_rs2[1]    <= r.rs2_1;
        dispatch_has_rd[1] <= r.h1;
        dispatch_valid     <= 1'b1;
    endtask

    // Model of one accepted pair
    task automatic predict_pair(input row_t r);
        logic [4:0] rd [2];
        logic [4:0] rs1 [2];
        logic [4:0] rs2 [2];
        logic       hrd [2];
        logic       wr [2];
        logic [5:0] old [2];
        mentry_t    e;
        rd  = '{r.rd0, r.rd1};
        rs1 = '{r.rs1_0, r.rs1_1};
        rs2 = '{r.rs2_0, r.rs2_1};
        hrd = '{r.h0, r.h1};
        for (int i = 0; i < 2; i++) begin
            exp_prd[i]  = free_fifo.pop_front();
            wr[i]       = hrd[i] && (rd[i] != 5'd0);
            exp_prs1[i] = rat_m[rs1[i]];
            exp_prs2[i] = rat_m[rs2[i]];
            old[i]      = wr[i] ? rat_m[rd[i]] : exp_prd[i];
            exp_idx[i]  = (2 * alloc_cnt + i) % 16;
        end
        if (wr[0] && rd[0] == rs1[1]) exp_prs1[1] = exp_prd[0];  // Bypass inside the pair
        if (wr[0] && rd[0] == rs2[1]) exp_prs2[1] = exp_prd[0];
        if (wr[0] && wr[1] && rd[0] == rd[1]) old[1] = exp_prd[0];
        for (int i = 0; i < 2; i++) begin
            e = '{rd: rd[i], has_rd: hrd[i], new_p: exp_prd[i], old_p: old[i],
                  idx: exp_idx[i], done: 1'b0};
            mrob.push_back(e);
            if (wr[i]) rat_m[rd[i]] = exp_prd[i];
        end
        alloc_cnt++;
    endtask

    task automatic check_rename();
        check_hex("rename_valid", 1, rename_valid);
        for (int i = 0; i < 2; i++) begin
            check_hex($sformatf("rename_prd[%0d]", i), exp_prd[i], rename_prd[i]);
            check_hex($sformatf("rename_prs1[%0d]", i), exp_prs1[i], rename_prs1[i]);
            check_hex($sformatf("rename_prs2[%0d]", i), exp_prs2[i], rename_prs2[i]);
            check_hex($sformatf("rename_rob_idx[%0d]", i), exp_idx[i], rename_rob_idx[i]);
        end
    endtask

    // Inputs stay up while the ROB is full and nothing may be accepted
    task automatic hold_while_full(input row_t r);
        @(posedge clk);
        drive_pair(r);
        repeat (4) begin
            @(negedge clk);
            check_hex("dispatch_ready", 0, dispatch_ready);
            check_hex("rename_valid", 0, rename_valid);
        end
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    task automatic complete_mask(input logic [15:0] mask);
        int q [$];
        int j;
        int tmp;
        for (int i = 0; i < 16; i++) begin
            if (mask[i]) q.push_back(i);
        end
        for (int i = q.size() - 1; i > 0; i--) begin
            j    = $urandom % (i + 1);
            tmp  = q[i];
            q[i] = q[j];
            q[j] = tmp;
        end
        while (q.size() >= 2) begin
            @(posedge clk);
            for (int k = 0; k < 2; k++) begin
                done_valid[k]   <= 1'b1;
                done_rob_idx[k] <= q[0];
                foreach (mrob[m]) begin
                    if (mrob[m].idx == q[0]) mrob[m].done = 1'b1;
                end
                void'(q.pop_front());
            end
        end
        @(posedge clk);
        done_valid[0] <= 1'b0;
        done_valid[1] <= 1'b0;
    endtask

    // Returns the model's old registers to its free FIFO in commit order
    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            if (mrob.size() < 2) begin
                $display("commit seen with fewer than two instructions in flight");
                errors++;
            end else begin
                if (!mrob[0].done || !mrob[1].done) begin
                    $display("commit of a pair that was not completed");
                    errors++;
                end
                for (int k = 0; k < 2; k++) begin
                    check_hex($sformatf("commit_rd[%0d]", k), mrob[0].rd, commit_rd[k]);
                    check_hex($sformatf("commit_has_rd[%0d]", k), mrob[0].has_rd,
                              commit_has_rd[k]);
                    check_hex($sformatf("commit_preg[%0d]", k), mrob[0].new_p, commit_preg[k]);
                    free_fifo.push_back(mrob[0].old_p);
                    void'(mrob.pop_front());
                end
            end
        end
    end

    initial begin
        #(NUM_ROWS * 20 * PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_ROWS * 20);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int err_start;
        void'($urandom(88));
        dispatch_valid = 1'b0;
        for (int i = 0; i < 2; i++) begin
            dispatch_rd[i]     = '0;
            dispatch_rs1[i]    = '0;
            dispatch_rs2[i]    = '0;
            dispatch_has_rd[i] = 1'b0;
            done_valid[i]      = 1'b0;
            done_rob_idx[i]    = '0;
        end
        errors    = 0;
        checks    = 0;
        alloc_cnt = 0;
        for (int i = 0; i < 32; i++) begin
            rat_m[i] = 6'(i);
            free_fifo.push_back(6'(32 + i));
        end
        rows[0]  = '{5, 1, 2, 1, 6, 5, 3, 1, 0, 'h0};
        rows[1]  = '{7, 5, 6, 1, 7, 7, 0, 1, 0, 'h0};
        rows[2]  = '{8, 7, 7, 1, 0, 8, 4, 1, 0, 'h0};
        rows[3]  = '{9, 9, 1, 0, 10, 9, 8, 1, 0, 'h0};
        rows[4]  = '{11, 10, 5, 1, 12, 11, 11, 1, 0, 'h0};
        rows[5]  = '{1, 1, 1, 1, 2, 1, 2, 1, 0, 'h0};
        rows[6]  = '{3, 0, 0, 1, 4, 3, 3, 0, 0, 'h0};
        rows[7]  = '{5, 6, 7, 1, 6, 5, 5, 1, 1, 'hFFFF};
        rows[8]  = '{13, 5, 6, 1, 14, 13, 2, 1, 0, 'h0};
        rows[9]  = '{15, 14, 13, 1, 15, 15, 1, 1, 0, 'h000F};
        rows[10] = '{16, 3, 4, 1, 17, 16, 16, 1, 0, 'h0};
        rows[11] = '{18, 17, 0, 1, 19, 18, 17, 1, 0, 'h00F0};
        rows[12] = '{20, 19, 18, 1, 5, 20, 20, 1, 0, 'h0};
        rows[13] = '{6, 5, 20, 1, 7, 6, 5, 1, 0, 'h0F00};
        rows[14] = '{8, 7, 6, 1, 9, 8, 7, 1, 0, 'h0};
        rows[15] = '{10, 9, 8, 1, 11, 10, 9, 1, 0, 'hF000};
        rows[16] = '{12, 11, 10, 1, 13, 12, 11, 1, 0, 'h0};
        rows[17] = '{14, 13, 12, 1, 15, 14, 13, 1, 0, 'h000F};
        rows[18] = '{16, 15, 14, 1, 17, 16, 15, 0, 0, 'h0};
        rows[19] = '{18, 17, 16, 1, 19, 18, 17, 1, 0, 'h00F0};

        while (rst_n !== 1'b1) begin
            @(negedge clk);
            check_hex("dispatch_ready", 0, dispatch_ready);
            check_hex("rename_valid", 0, rename_valid);
            check_hex("commit_valid", 0, commit_valid);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_start = errors;
            @(posedge clk);
            drive_pair(rows[r]);
            @(negedge clk);
            while (!dispatch_ready) begin
                check_hex("rename_valid", 0, rename_valid);  // Nothing renamed while stalled
                @(negedge clk);
            end
            @(posedge clk);
            dispatch_valid <= 1'b0;
            predict_pair(rows[r]);
            @(negedge clk);
            check_rename();
            if (rows[r].full_chk) begin
                check_hex("dispatch_ready", 0, dispatch_ready);
                hold_while_full(rows[r]);
            end
            complete_mask(rows[r].done_mask);
            $display("test %0d: %s", r, (errors == err_start) ? "ok" : "FAILED");
        end

        while (mrob.size() != 0) @(negedge clk);  // Drain outstanding commits
        repeat (3) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : rename_dispatch_tb

// File: tb/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;  // Released on an edge like any other input
    end

endmodule : tb_clk_gen
